// File: design/float_adder.sv
`timescale 1ns/1ps

module float_adder (
	input  neuron_pkg::fp32_t a,
	input  neuron_pkg::fp32_t b,
	output neuron_pkg::fp32_t s
);
	import neuron_pkg::*;

	fp32_t             a_ftz;
	fp32_t             b_ftz;
	fp32_t             larger;
	fp32_t             smaller;
	logic [23:0]       mant_large;
	logic [23:0]       mant_small;
	logic [23:0]       aligned;
	logic [7:0]        shift;
	logic [24:0]       mant_sum;
	logic [23:0]       norm;
	logic [4:0]        lz;
	logic              found;
	logic [22:0]       mant_res;
	logic signed [9:0] exp_res;

	always_comb
	begin
		a_ftz = a;
		b_ftz = b;
		if (a.f.exponent == 8'd0)
			a_ftz.bits = 32'd0;
		if (b.f.exponent == 8'd0)
			b_ftz.bits = 32'd0;

		// Order by magnitude
		if (a_ftz.bits[30:0] >= b_ftz.bits[30:0])
		begin
			larger  = a_ftz;
			smaller = b_ftz;
		end
		else
		begin
			larger  = b_ftz;
			smaller = a_ftz;
		end

		mant_large = {larger.f.exponent != 8'd0, larger.f.mantissa};
		mant_small = {smaller.f.exponent != 8'd0, smaller.f.mantissa};
		shift      = larger.f.exponent - smaller.f.exponent;
		aligned    = (shift > 8'd23) ? 24'd0 : (mant_small >> shift);

		if (larger.f.sign == smaller.f.sign)
			mant_sum = {1'b0, mant_large} + {1'b0, aligned};
		else
			mant_sum = {1'b0, mant_large} - {1'b0, aligned};

		// Leading zero count below the carry bit
		lz    = 5'd0;
		found = 1'b0;
		for (int i = 23; i >= 0; i--)
		begin
			if (!found)
			begin
				if (mant_sum[i])
					found = 1'b1;
				else
					lz = lz + 5'd1;
			end
		end
		norm = mant_sum[23:0] << lz;

		if (mant_sum[24])
		begin
			mant_res = mant_sum[23:1];
			exp_res  = $signed({2'b00, larger.f.exponent}) + 10'sd1;
		end
		else
		begin
			mant_res = norm[22:0];
			exp_res  = $signed({2'b00, larger.f.exponent}) - $signed({5'b00000, lz});
		end

		// Exact cancellation gives +0
		if (mant_sum == 25'd0)
			s.bits = 32'd0;
		else if (exp_res <= 10'sd0)
			s.bits = {larger.f.sign, 31'd0};
		else if (exp_res >= 10'sd255)
			s.bits = {larger.f.sign, 8'hff, 23'd0};
		else
			s.bits = {larger.f.sign, exp_res[7:0], mant_res};
	end

endmodule

// File: design/float_mult.sv
`timescale 1ns/1ps

module float_mult (
	input  neuron_pkg::fp32_t a,
	input  neuron_pkg::fp32_t b,
	output neuron_pkg::fp32_t p
);

	logic [23:0]       mant_a;
	logic [23:0]       mant_b;
	logic [47:0]       prod;
	logic [22:0]       mant_res;
	logic signed [9:0] exp_res;
	logic              sign_res;
	logic              zero_in;

	always_comb
	begin
		mant_a   = {1'b1, a.f.mantissa};
		mant_b   = {1'b1, b.f.mantissa};
		prod     = 48'(mant_a) * 48'(mant_b);
		sign_res = a.f.sign ^ b.f.sign;
		// Subnormal operands count as zero
		zero_in  = (a.f.exponent == 8'd0) || (b.f.exponent == 8'd0);

		exp_res = $signed({2'b00, a.f.exponent}) + $signed({2'b00, b.f.exponent}) - 10'sd127;

		// Product of two 1.x values lies in [1,4)
		if (prod[47])
		begin
			mant_res = prod[46:24];
			exp_res  = exp_res + 10'sd1;
		end
		else
		begin
			mant_res = prod[45:23];
		end

		if (zero_in || exp_res <= 10'sd0)
		begin
			p.bits = {sign_res, 31'd0};
		end
		else if (exp_res >= 10'sd255)
		begin
			p.bits = {sign_res, 8'hff, 23'd0};
		end
		else
		begin
			p.bits = {sign_res, exp_res[7:0], mant_res};
		end
	end

endmodule

// File: design/neuron_node.sv
`timescale 1ns/1ps

module neuron_node (
	input  logic        clk,
	input  logic        arst_n,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [7:0]  paddr,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic        pready,
	output logic        pslverr
);
	import neuron_pkg::*;

	half_operands_t lo_ops;
	half_operands_t hi_ops;
	half_sum_t      lo_sum;
	half_sum_t      hi_sum;
	fp32_t          result;
	logic           start;
	logic           done;

	neuron_regs regs (
		.clk(clk),
		.arst_n(arst_n),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.lo_ops(lo_ops),
		.hi_ops(hi_ops),
		.start(start),
		.result(result),
		.done(done)
	);

	// Two half-sums run side by side
	partial_mac lo_mac (
		.clk(clk),
		.arst_n(arst_n),
		.start(start),
		.operands(lo_ops),
		.sum(lo_sum)
	);

	partial_mac hi_mac (
		.clk(clk),
		.arst_n(arst_n),
		.start(start),
		.operands(hi_ops),
		.sum(hi_sum)
	);

	node_combine combine (
		.clk(clk),
		.arst_n(arst_n),
		.start(start),
		.lo_sum(lo_sum),
		.hi_sum(hi_sum),
		.result(result),
		.done(done)
	);

endmodule

// File: design/neuron_pkg.sv
package neuron_pkg;

	// ####################
	// Sizes and timing
	// ####################
	localparam int N_INPUTS     = 10;
	localparam int HALF_LEN     = 5;
	localparam int NODE_LATENCY = 7;

	// ####################
	// Register map
	// ####################
	localparam logic [7:0] ADDR_INPUT_BASE  = 8'h00;
	localparam logic [7:0] ADDR_WEIGHT_BASE = 8'h40;
	localparam logic [7:0] ADDR_CTRL        = 8'h80;
	localparam logic [7:0] ADDR_STATUS      = 8'h84;
	localparam logic [7:0] ADDR_RESULT      = 8'h88;

	typedef struct packed {
		logic        sign;
		logic [7:0]  exponent;
		logic [22:0] mantissa;
	} fp32_fields_t;

	// Same word, seen as raw bits or as IEEE fields
	typedef union packed {
		logic [31:0]  bits;
		fp32_fields_t f;
	} fp32_t;

	typedef struct packed {
		fp32_t [HALF_LEN-1:0] inputs;
		fp32_t [HALF_LEN-1:0] weights;
	} half_operands_t;

	typedef struct packed {
		logic  valid;
		fp32_t sum;
	} half_sum_t;

	// Trained weights W0..W9
	localparam logic [31:0] WEIGHT_RESET [N_INPUTS] = '{
		32'hbe75c37b, 32'hbe913d2b, 32'hbdd63640, 32'hbee069db, 32'hbe74529e,
		32'h3da30fe1, 32'h3e1177be, 32'hbdd6aba3, 32'hbe69abc8, 32'hbbf90380
	};

endpackage

// File: design/neuron_regs.sv
`timescale 1ns/1ps

module neuron_regs (
	input  logic                       clk,
	input  logic                       arst_n,
	input  logic                       psel,
	input  logic                       penable,
	input  logic                       pwrite,
	input  logic [7:0]                 paddr,
	input  logic [31:0]                pwdata,
	output logic [31:0]                prdata,
	output logic                       pready,
	output logic                       pslverr,
	output neuron_pkg::half_operands_t lo_ops,
	output neuron_pkg::half_operands_t hi_ops,
	output logic                       start,
	input  neuron_pkg::fp32_t          result,
	input  logic                       done
);
	import neuron_pkg::*;

	fp32_t      in_q [N_INPUTS];
	fp32_t      w_q [N_INPUTS];
	logic [3:0] idx;
	logic       access;
	logic       is_input;
	logic       is_weight;
	logic       is_ctrl;
	logic       is_status;
	logic       is_result;
	logic       mapped;
	logic       wr_ok;
	logic       busy_q;
	logic       busy;

	// ####################
	// Address decode
	// ####################
	assign idx       = paddr[5:2];
	assign access    = psel && penable;
	assign is_input  = (paddr[7:6] == ADDR_INPUT_BASE[7:6]) && (paddr[1:0] == 2'b00) &&
	                   (idx < 4'(N_INPUTS));
	assign is_weight = (paddr[7:6] == ADDR_WEIGHT_BASE[7:6]) && (paddr[1:0] == 2'b00) &&
	                   (idx < 4'(N_INPUTS));
	assign is_ctrl   = (paddr == ADDR_CTRL);
	assign is_status = (paddr == ADDR_STATUS);
	assign is_result = (paddr == ADDR_RESULT);
	assign mapped    = is_input || is_weight || is_ctrl || is_status || is_result;

	assign pready  = 1'b1;
	assign pslverr = access && (!mapped ||
	                 (pwrite && (is_status || is_result)) ||
	                 (pwrite && busy && (is_input || is_weight || is_ctrl)));
	assign wr_ok   = access && pwrite && !pslverr;

	// Busy covers the start cycle and the run up to done
	assign busy = start || (busy_q && !done);

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			start  <= 1'b0;
			busy_q <= 1'b0;
			for (int i = 0; i < N_INPUTS; i++)
			begin
				in_q[i].bits <= 32'd0;
				w_q[i].bits  <= WEIGHT_RESET[i];
			end
		end
		else
		begin
			start <= wr_ok && is_ctrl && pwdata[0];
			if (start)
				busy_q <= 1'b1;
			else if (done)
				busy_q <= 1'b0;
			if (wr_ok && is_input)
				in_q[idx].bits <= pwdata;
			if (wr_ok && is_weight)
				w_q[idx].bits <= pwdata;
		end
	end

	always_comb
	begin
		prdata = 32'd0;
		if (is_input)
			prdata = in_q[idx].bits;
		else if (is_weight)
			prdata = w_q[idx].bits;
		else if (is_status)
			prdata = {30'd0, done, busy};
		else if (is_result)
			prdata = result.bits;
	end

	// Inputs 0..4 to the low half, 5..9 to the high half
	always_comb
	begin
		for (int i = 0; i < HALF_LEN; i++)
		begin
			lo_ops.inputs[i]  = in_q[i];
			lo_ops.weights[i] = w_q[i];
			hi_ops.inputs[i]  = in_q[i + HALF_LEN];
			hi_ops.weights[i] = w_q[i + HALF_LEN];
		end
	end

endmodule

// File: design/node_combine.sv
`timescale 1ns/1ps

module node_combine (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  start,
	input  neuron_pkg::half_sum_t lo_sum,
	input  neuron_pkg::half_sum_t hi_sum,
	output neuron_pkg::fp32_t     result,
	output logic                  done
);
	import neuron_pkg::*;

	fp32_t total;

	float_adder add (
		.a(lo_sum.sum),
		.b(hi_sum.sum),
		.s(total)
	);

	// Both halves finish in the same cycle
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			result.bits <= 32'd0;
			done        <= 1'b0;
		end
		else if (start)
		begin
			done <= 1'b0;
		end
		else if (lo_sum.valid && hi_sum.valid)
		begin
			// Rectifier, negative zero included
			if (total.f.sign)
				result.bits <= 32'd0;
			else
				result <= total;
			done <= 1'b1;
		end
	end

endmodule

// File: design/partial_mac.sv
`timescale 1ns/1ps

module partial_mac (
	input  logic                       clk,
	input  logic                       arst_n,
	input  logic                       start,
	input  neuron_pkg::half_operands_t operands,
	output neuron_pkg::half_sum_t      sum
);
	import neuron_pkg::*;

	logic       active;
	logic       valid;
	logic [2:0] idx;
	logic       last;
	fp32_t      product;
	fp32_t      acc;
	fp32_t      acc_next;

	assign last = (idx == 3'(HALF_LEN - 1));

	float_mult mult (
		.a(operands.inputs[idx]),
		.b(operands.weights[idx]),
		.p(product)
	);

	float_adder add (
		.a(acc),
		.b(product),
		.s(acc_next)
	);

	// ####################
	// Pair sequencer
	// ####################
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			active <= 1'b0;
			valid  <= 1'b0;
			idx    <= 3'd0;
		end
		else if (start)
		begin
			active <= 1'b1;
			valid  <= 1'b0;
			idx    <= 3'd0;
		end
		else
		begin
			valid <= active && last;
			if (active)
			begin
				idx <= last ? 3'd0 : idx + 3'd1;
				if (last)
					active <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (start)
			acc.bits <= 32'd0;
		else if (active)
			acc <= acc_next;
	end

	assign sum.valid = valid;
	assign sum.sum   = acc;

endmodule

// File: neuron_node.f
design/neuron_pkg.sv
design/float_mult.sv
design/float_adder.sv
design/partial_mac.sv
design/node_combine.sv
design/neuron_regs.sv
design/neuron_node.sv
tb/neuron_node_checks.sv
tb/neuron_node_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module neuron_node_tb -f neuron_node.f

out=$(./obj_dir/Vneuron_node_tb || true)
echo "$out"

if echo "$out" | grep -qxF "Done: no errors"; then
	exit 0
fi
exit 1

// File: tb/neuron_node_checks.sv
`timescale 1ns/1ps

module neuron_node_checks (
	input  logic        clk,
	input  logic        arst_n,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [7:0]  paddr,
	input  logic [31:0] pwdata,
	input  logic [31:0] prdata,
	input  logic        pready,
	input  logic        pslverr,
	input  logic [31:0] exp_result,
	output logic        failed
);
	import neuron_pkg::*;

	// Inputs in slots 0..9, weights in slots 10..19
	logic [31:0] shadow [2 * N_INPUTS];
	logic        started;
	int          since_start;
	logic        busy_exp;
	logic [31:0] status_exp;
	logic        is_data;
	logic        is_ctrl;
	logic        is_status;
	logic        is_result;
	logic        exp_err;
	logic        access;
	int          slot;

	// ####################
	// Expected decode
	// ####################
	assign access     = psel && penable;
	assign is_ctrl    = (paddr == ADDR_CTRL);
	assign is_status  = (paddr == ADDR_STATUS);
	assign is_result  = (paddr == ADDR_RESULT);
	assign busy_exp   = started && (since_start < NODE_LATENCY);
	assign status_exp = {30'd0, started && !busy_exp, busy_exp};
	assign exp_err    = !(is_data || is_ctrl || is_status || is_result) ||
	                    (pwrite && (is_status || is_result)) ||
	                    (pwrite && busy_exp && (is_data || is_ctrl));

	always_comb
	begin
		is_data = 1'b0;
		slot    = 0;
		if (paddr[1:0] == 2'b00 && 8'(paddr - ADDR_INPUT_BASE) < 8'(4 * N_INPUTS))
		begin
			is_data = 1'b1;
			slot    = int'(8'(paddr - ADDR_INPUT_BASE)) / 4;
		end
		else if (paddr[1:0] == 2'b00 && 8'(paddr - ADDR_WEIGHT_BASE) < 8'(4 * N_INPUTS))
		begin
			is_data = 1'b1;
			slot    = N_INPUTS + int'(8'(paddr - ADDR_WEIGHT_BASE)) / 4;
		end
	end

	task automatic report_mismatch(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("MISMATCH at %0t ns: %s (paddr 0x%h) expected 0x%h, got 0x%h",
			$time, name, paddr, expected, actual);
		failed = 1'b1;
	endtask

	// ####################
	// APB access checks
	// ####################
	always @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			failed      = 1'b0;
			started     <= 1'b0;
			since_start <= 0;
			for (int i = 0; i < N_INPUTS; i++)
			begin
				shadow[i]            <= 32'd0;
				shadow[N_INPUTS + i] <= WEIGHT_RESET[i];
			end
		end
		else
		begin
			if (access)
			begin
				assert (pready)
				else
					report_mismatch("pready", 32'd1, 32'(pready));
				assert (pslverr == exp_err)
				else
					report_mismatch("pslverr", 32'(exp_err), 32'(pslverr));
				if (!pwrite && is_data)
					assert (prdata == shadow[slot])
					else
						report_mismatch("prdata", shadow[slot], prdata);
				if (!pwrite && is_status)
					assert (prdata == status_exp)
					else
						report_mismatch("prdata", status_exp, prdata);
				if (!pwrite && is_result)
					assert (prdata == exp_result)
					else
						report_mismatch("prdata", exp_result, prdata);
				if (pwrite && !exp_err && is_data)
					shadow[slot] <= pwdata;
			end
			if (started)
				since_start <= since_start + 1;
			// Accepted start restarts the latency count
			if (access && pwrite && !exp_err && is_ctrl && pwdata[0])
			begin
				started     <= 1'b1;
				since_start <= 0;
			end
		end
	end

endmodule

// File: tb/neuron_node_tb.sv
`timescale 1ns/1ps

module neuron_node_tb;
	import neuron_pkg::*;

	localparam int N_TESTS    = 10;
	localparam int MARGIN     = 300;
	localparam int POLL_LIMIT = 16;

	logic        clk;
	logic        arst_n;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [7:0]  paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;
	logic [31:0] exp_result;
	logic        check_failed;
	logic [31:0] rd_data;
	logic [31:0] in_bits [N_INPUTS];
	logic [31:0] w_bits [N_INPUTS];
	logic [7:0]  bad_addr [7] = '{8'h28, 8'h3c, 8'h42, 8'h68, 8'h7c, 8'h8c, 8'hfc};
	int          in_q [N_INPUTS];
	int          w_q [N_INPUTS];
	int          seed;

	neuron_node uut (.*);

	neuron_node_checks checks (.*, .failed(check_failed));

	always #5 clk = ~clk;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Done: errors found");
		$fatal(1, "run stopped");
	endtask

	// Value is units * 2^-frac_bits and exact below 2^24 units
	function automatic logic [31:0] to_fp(input int units, input int frac_bits);
		int          mag;
		int          msb;
		logic [31:0] word;
		mag = (units < 0) ? -units : units;
		msb = 0;
		if (mag == 0)
			return 32'd0;
		for (int i = 0; i < 31; i++)
			if (mag[i])
				msb = i;
		word[31]    = (units < 0);
		word[30:23] = 8'(127 + msb - frac_bits);
		word[22:0]  = 23'(mag << (23 - msb));
		return word;
	endfunction

	task automatic bus_transfer(input logic write, input logic [7:0] addr,
		input logic [31:0] data);
		@(negedge clk);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = write;
		paddr   = addr;
		pwdata  = data;
		@(negedge clk);
		penable = 1'b1;
		rd_data = prdata;
	endtask

	task automatic bus_idle();
		@(negedge clk);
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic encode_operands();
		for (int i = 0; i < N_INPUTS; i++)
		begin
			in_bits[i] = to_fp(in_q[i], 2);
			w_bits[i]  = to_fp(w_q[i], 2);
		end
	endtask

	// Integers -8..8 shifted up to 3 places in quarter units
	task automatic pick_operands();
		for (int i = 0; i < N_INPUTS; i++)
		begin
			in_q[i] = ($random(seed) % 9) <<< ($random(seed) & 3);
			w_q[i]  = ($random(seed) % 9) <<< ($random(seed) & 3);
		end
		encode_operands();
	endtask

	task automatic start_node();
		int sum;
		sum = 0;
		for (int i = 0; i < N_INPUTS; i++)
			sum += in_q[i] * w_q[i];
		exp_result = (sum > 0) ? to_fp(sum, 4) : 32'd0;
		for (int i = 0; i < N_INPUTS; i++)
		begin
			bus_transfer(1'b1, ADDR_INPUT_BASE + 8'(4 * i), in_bits[i]);
			bus_transfer(1'b1, ADDR_WEIGHT_BASE + 8'(4 * i), w_bits[i]);
		end
		bus_transfer(1'b1, ADDR_CTRL, 32'd1);
	endtask

	// Skew shifts the status polls by one cycle
	task automatic finish_node(input int skew);
		int polls;
		polls   = 0;
		rd_data = 32'd0;
		if (skew != 0)
			bus_idle();
		while (!rd_data[1])
		begin
			if (polls == POLL_LIMIT)
				abort_run("done flag never rose while polling the status register");
			bus_transfer(1'b0, ADDR_STATUS, 32'd0);
			polls++;
		end
		bus_transfer(1'b0, ADDR_RESULT, 32'd0);
		bus_idle();
	endtask

	initial
	begin
		seed       = 32'hd7757cb6;
		clk        = 1'b0;
		arst_n     = 1'b0;
		psel       = 1'b0;
		penable    = 1'b0;
		pwrite     = 1'b0;
		paddr      = 8'd0;
		pwdata     = 32'd0;
		exp_result = 32'd0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;

		// Reset values
		for (int i = 0; i < N_INPUTS; i++)
		begin
			bus_transfer(1'b0, ADDR_INPUT_BASE + 8'(4 * i), 32'd0);
			bus_transfer(1'b0, ADDR_WEIGHT_BASE + 8'(4 * i), 32'd0);
		end
		bus_transfer(1'b0, ADDR_RESULT, 32'd0);
		bus_transfer(1'b0, ADDR_STATUS, 32'd0);
		bus_idle();

		for (int t = 0; t < 4; t++)
		begin
			pick_operands();
			start_node();
			finish_node(t % 2);
		end

		// Negative sum, then inputs of negative zero
		for (int i = 0; i < N_INPUTS; i++)
		begin
			in_q[i] = i + 1;
			w_q[i]  = -(i % 3 + 1);
		end
		encode_operands();
		start_node();
		finish_node(0);
		pick_operands();
		for (int i = 0; i < N_INPUTS; i++)
			in_q[i] = 0;
		encode_operands();
		for (int i = 0; i < N_INPUTS; i++)
			in_bits[i] = 32'h80000000;
		start_node();
		finish_node(1);

		// Writes while busy are refused
		pick_operands();
		start_node();
		bus_transfer(1'b1, ADDR_CTRL, 32'd1);
		bus_transfer(1'b1, ADDR_INPUT_BASE, 32'h3f800000);
		bus_transfer(1'b1, ADDR_WEIGHT_BASE + 8'd36, 32'h40000000);
		finish_node(0);
		bus_transfer(1'b0, ADDR_INPUT_BASE, 32'd0);
		bus_transfer(1'b0, ADDR_WEIGHT_BASE + 8'd36, 32'd0);

		for (int i = 0; i < 7; i++)
		begin
			bus_transfer(1'b0, bad_addr[i], 32'd0);
			bus_transfer(1'b1, bad_addr[i], 32'h12345678);
		end
		bus_transfer(1'b1, ADDR_STATUS, 32'h3);
		bus_transfer(1'b1, ADDR_RESULT, 32'h3f800000);
		bus_transfer(1'b0, ADDR_RESULT, 32'd0);
		bus_idle();

		// Subnormal input counts as zero even against a huge weight
		pick_operands();
		in_q[3] = 0;
		encode_operands();
		in_bits[3] = 32'h00400000;
		w_bits[3]  = 32'h7f000000;
		start_node();
		finish_node(1);

		if (check_failed === 1'b1)
			abort_run("assertion failures were recorded during the run");
		else
		begin
			$display("Done: no errors");
			$finish;
		end
	end

	initial
	begin
		wait (check_failed === 1'b1);
		abort_run("checker stopped the run at the first error");
	end

	initial
	begin
		#((N_TESTS * 40 + MARGIN) * 10);
		abort_run("watchdog expired before the test sequence finished");
	end

endmodule
